//--- dbg_mailbox.sv
// debug word mailbox
// keeps the most recent word per user instruction for the soc side
// each channel has a valid flag cleared by rd_ack, and a sticky
// overflow flag set when an unread word gets overwritten

`timescale 1ns/1ps
`default_nettype none

`include "jtag_dbg_consts.svh"

module dbg_mailbox (
	input  wire                                        clk48m,
	input  wire                                        jrstn,
	input  jtag_dbg_pkg::dbg_word_t                    word,
	input  wire                                        word_strobe,
	input  wire  [`DBG_CHANNELS-1:0]                   rd_ack,
	output logic [`DBG_CHANNELS-1:0][`DBG_WIDTH-1:0]   mbox_data,
	output logic [`DBG_CHANNELS-1:0]                   mbox_valid,
	output logic [`DBG_CHANNELS-1:0]                   mbox_overflow
);

	logic [`DBG_CHANNELS-1:0] hit;  // strobed word is for this channel

	// sel bit picks the channel
	always_comb begin
		for (int ch = 0; ch < `DBG_CHANNELS; ch++) begin
			hit[ch] = word_strobe && (int'(word.sel) == ch);
		end
	end

	// flags, a read in the same cycle as a new word counts first
	always_ff @(posedge clk48m) begin
		if (!jrstn) begin
			mbox_valid    <= '0;
			mbox_overflow <= '0;
		end else begin
			for (int ch = 0; ch < `DBG_CHANNELS; ch++) begin
				if (hit[ch]) begin
					mbox_valid[ch] <= 1'b1;
					if (mbox_valid[ch] && !rd_ack[ch]) begin
						mbox_overflow[ch] <= 1'b1;  // old word lost, only reset clears this
					end
				end else if (rd_ack[ch]) begin
					mbox_valid[ch] <= 1'b0;  // data stays readable
				end
			end
		end
	end

	// payload, no back-pressure so always overwritten
	always_ff @(posedge clk48m) begin
		for (int ch = 0; ch < `DBG_CHANNELS; ch++) begin
			if (hit[ch]) begin
				mbox_data[ch] <= word.data;
			end
		end
	end

endmodule

`default_nettype wire

//--- jtag_dbg_asserts.sv
// protocol checks for the jtag debug register receiver
// bound into jtag_dbg_top, covers the pulse widths, the strobe to
// valid timing per channel and quiet outputs after reset

`timescale 1ns/1ps
`default_nettype none

`include "jtag_dbg_consts.svh"

module jtag_dbg_asserts (
	input wire                       clk48m,
	input wire                       jrstn,
	input wire                       tck_rise,
	input wire                       word_strobe,
	input jtag_dbg_pkg::dbg_word_t   word,
	input wire [`DBG_CHANNELS-1:0]   mbox_valid,
	input wire [`DBG_CHANNELS-1:0]   mbox_overflow
);

	// single-cycle pulses
	a_tck_rise_pulse: assert property (@(posedge clk48m) disable iff (!jrstn)
		tck_rise |=> !tck_rise)
		else $error("tck_rise high for more than one cycle");

	a_word_strobe_pulse: assert property (@(posedge clk48m) disable iff (!jrstn)
		word_strobe |=> !word_strobe)
		else $error("word_strobe high for more than one cycle");

	// valid follows the strobe by one cycle, on the channel picked by sel
	for (genvar ch = 0; ch < `DBG_CHANNELS; ch++) begin : g_chan
		a_valid_after_strobe: assert property (@(posedge clk48m) disable iff (!jrstn)
			word_strobe && (int'(word.sel) == ch) |=> mbox_valid[ch])
			else $error("mbox_valid[%0d] not set one cycle after word_strobe", ch);

		// and never rises without a strobe for this channel
		a_valid_rise_cause: assert property (@(posedge clk48m) disable iff (!jrstn)
			$rose(mbox_valid[ch]) |-> $past(word_strobe && (int'(word.sel) == ch)))
			else $error("mbox_valid[%0d] rose without a matching word_strobe", ch);
	end

	// control outputs low in the cycle after a reset edge
	a_reset_quiet: assert property (@(posedge clk48m)
		!jrstn |=> (!tck_rise && !word_strobe && mbox_valid == '0 && mbox_overflow == '0))
		else $error("control output high in the cycle after reset");

endmodule

`default_nettype wire

//--- jtag_dbg_consts.svh
// jtag debug register receiver, shared constants
// width of the user data register, depth of the tck sample chain
// and the number of mailbox channels

`ifndef JTAG_DBG_CONSTS_SVH
`define JTAG_DBG_CONSTS_SVH

// user DR length, same for IR 0x32 and IR 0x38
`define DBG_WIDTH 32

// tck sample chain length, edge found between the last two stages
// 3 or 5 also work, only the latency moves
`define DBG_SYNC_DEPTH 4

// one mailbox channel per user instruction
`define DBG_CHANNELS 2

`endif

//--- jtag_dbg_pkg.sv
// jtag debug register receiver, shared types
// packed groupings of the tap pins, the synchronised tap levels
// and the captured debug word

`default_nettype none

`include "jtag_dbg_consts.svh"

package jtag_dbg_pkg;

	// raw outputs of the JTAGG primitive
	typedef struct packed {
		logic tdi;      // data in
		logic tck;      // test clock, sampled as a level here
		logic shift;    // DR shift state
		logic update;   // DR update state
		logic ce1;      // IR 0x32 selected
		logic ce2;      // IR 0x38 selected
	} jtag_pins_t;

	// tap levels after the synchroniser, tck is replaced by a pulse
	typedef struct packed {
		logic tdi;
		logic shift;
		logic update;
		logic ce1;
		logic ce2;
	} tap_sample_t;

	// captured DR contents plus the instruction it came from
	typedef struct packed {
		logic                  sel;   // 0 for IR 0x32, 1 for IR 0x38
		logic [`DBG_WIDTH-1:0] data;
	} dbg_word_t;

endpackage

`default_nettype wire

//--- jtag_dbg_top.f
+incdir+.
jtag_dbg_pkg.sv
jtag_tck_sync.sv
jtag_dr_capture.sv
dbg_mailbox.sv
jtag_dbg_top.sv
jtag_dbg_asserts.sv
tb_jtag_dbg.sv

//--- jtag_dbg_top.sv
// jtag debug register receiver, top level
// tap pins in, per-instruction debug words out in the clk48m domain
// sampler -> data register -> mailbox, no tdo readback

`timescale 1ns/1ps
`default_nettype none

`include "jtag_dbg_consts.svh"

module jtag_dbg_top (
	input  wire                                       clk48m,
	input  wire                                       jrstn,
	input  jtag_dbg_pkg::jtag_pins_t                  pins,       // from the JTAGG primitive
	input  wire  [`DBG_CHANNELS-1:0]                  rd_ack,
	output logic [`DBG_CHANNELS-1:0][`DBG_WIDTH-1:0]  mbox_data,
	output logic [`DBG_CHANNELS-1:0]                  mbox_valid,
	output logic [`DBG_CHANNELS-1:0]                  mbox_overflow
);

	jtag_dbg_pkg::tap_sample_t tap;          // synchronised tap levels
	logic                      tck_rise;     // one pulse per tck rising edge
	jtag_dbg_pkg::dbg_word_t   word;         // captured DR plus select
	logic                      word_strobe;  // word is new this cycle

	jtag_tck_sync #(
		.SYNC_DEPTH(`DBG_SYNC_DEPTH)
	) u_tck_sync (
		.clk48m   (clk48m),
		.jrstn    (jrstn),
		.pins     (pins),
		.tap      (tap),
		.tck_rise (tck_rise)
	);

	jtag_dr_capture u_dr_capture (
		.clk48m      (clk48m),
		.jrstn       (jrstn),
		.tck_rise    (tck_rise),
		.tap         (tap),
		.word        (word),
		.word_strobe (word_strobe)
	);

	dbg_mailbox u_mailbox (
		.clk48m        (clk48m),
		.jrstn         (jrstn),
		.word          (word),
		.word_strobe   (word_strobe),
		.rd_ack        (rd_ack),
		.mbox_data     (mbox_data),
		.mbox_valid    (mbox_valid),
		.mbox_overflow (mbox_overflow)
	);

endmodule

`default_nettype wire

//--- jtag_dr_capture.sv
// jtag user data register
// shifts tdi in on each tck rise, remembers which user instruction
// is selected and hands out the word when the tap goes to update

`timescale 1ns/1ps
`default_nettype none

`include "jtag_dbg_consts.svh"

module jtag_dr_capture (
	input  wire                       clk48m,
	input  wire                       jrstn,
	input  wire                       tck_rise,
	input  jtag_dbg_pkg::tap_sample_t tap,
	output jtag_dbg_pkg::dbg_word_t   word,
	output logic                      word_strobe
);

	logic [`DBG_WIDTH-1:0] shift_reg;  // the DR itself
	logic                  sel;        // 1 when IR 0x38 was last selected
	logic                  old_shift;  // shift level seen at the previous tck rise

	// shift state is acted on one tck late, as the tap enters
	// shift-dr on an edge and the first data bit comes on the next one
	always_ff @(posedge clk48m) begin
		word_strobe <= 1'b0;  // pulse by default
		if (!jrstn) begin
			old_shift <= tap.shift;  // follows the pin even in reset
			shift_reg <= '0;
			sel       <= 1'b0;
		end else if (tck_rise) begin
			if (old_shift) begin
				// lsb first on the wire, so it ends up in bit 0
				shift_reg <= {tap.tdi, shift_reg[`DBG_WIDTH-1:1]};
			end
			if (tap.ce1 || tap.ce2) begin
				sel <= tap.ce2;  // held between accesses
			end
			if (tap.update) begin
				word_strobe <= 1'b1;  // register value before this edge's shift
			end
			old_shift <= tap.shift;
		end
	end

	// word is payload, only qualified by word_strobe
	always_ff @(posedge clk48m) begin
		if (tck_rise && tap.update) begin
			word.data <= shift_reg;
			word.sel  <= sel;
		end
	end

endmodule

`default_nettype wire

//--- jtag_tck_sync.sv
// tck sampler
// brings the tap pins into the clk48m domain and gives a one-cycle
// pulse for every tck rising edge, a few cycles after the real edge

`timescale 1ns/1ps
`default_nettype none

`include "jtag_dbg_consts.svh"

module jtag_tck_sync #(
	parameter int SYNC_DEPTH = `DBG_SYNC_DEPTH
) (
	input  wire                      clk48m,
	input  wire                      jrstn,
	input  jtag_dbg_pkg::jtag_pins_t pins,
	output jtag_dbg_pkg::tap_sample_t tap,
	output logic                     tck_rise
);

	logic [SYNC_DEPTH-1:0]     tck_chain;  // bit 0 is the newest sample
	jtag_dbg_pkg::tap_sample_t tap_meta;   // first sync stage

	// tck history, oldest stage low and next one high means a rising edge
	always_ff @(posedge clk48m) begin
		if (!jrstn) begin
			tck_chain <= '0;
			tck_rise  <= 1'b0;
		end else begin
			tck_chain <= {tck_chain[SYNC_DEPTH-2:0], pins.tck};
			tck_rise  <= ~tck_chain[SYNC_DEPTH-1] & tck_chain[SYNC_DEPTH-2];
		end
	end

	// other tap levels only need a plain two-flop synchroniser
	// they are held long around each tck edge, so this settles well before tck_rise
	always_ff @(posedge clk48m) begin
		tap_meta <= '{
			tdi:    pins.tdi,
			shift:  pins.shift,
			update: pins.update,
			ce1:    pins.ce1,
			ce2:    pins.ce2
		};
		tap <= tap_meta;  // second stage
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# builds the jtag debug receiver testbench with verilator and runs it
# the result is taken from the simulation log

cd "$(dirname "$0")" || exit 1

TOP=tb_jtag_dbg
BUILD_LOG=build.log
SIM_LOG=sim.log

echo "building $TOP"
verilator --binary --timing --assert -j 0 \
	--top-module "$TOP" \
	-f jtag_dbg_top.f \
	-o "V$TOP" > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "verilator build failed with status $status"
	exit 1
fi

echo "running $TOP"
"./obj_dir/V$TOP" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Testbench passed$" "$SIM_LOG"; then
	echo "simulation PASS"
	exit 0
else
	echo "simulation FAIL"
	exit 1
fi

//--- tb_jtag_dbg.sv
// testbench for the jtag debug register receiver
// bit-bangs the tap pins like the JTAGG primitive, plays the soc side
// of the mailbox and checks every output against a mailbox model

`timescale 1ns/1ps
`default_nettype none

`include "jtag_dbg_consts.svh"

module tb_jtag_dbg;

	localparam int TCK_HALF        = 4;             // clk48m cycles per tck phase
	localparam int TCK_PERIOD      = 2 * TCK_HALF;
	localparam int NUM_ACCESSES    = 6;
	localparam int VALID_AT        = 6;             // tck drive edge, sampling edge, then 5
	localparam int WATCHDOG_CYCLES = NUM_ACCESSES * 40 * TCK_PERIOD + 200;

	logic                                     clk48m;
	logic                                     jrstn;
	jtag_dbg_pkg::jtag_pins_t                 pins;
	logic [`DBG_CHANNELS-1:0]                 rd_ack;
	logic [`DBG_CHANNELS-1:0][`DBG_WIDTH-1:0] mbox_data;
	logic [`DBG_CHANNELS-1:0]                 mbox_valid;
	logic [`DBG_CHANNELS-1:0]                 mbox_overflow;

	// mailbox model
	logic [`DBG_CHANNELS-1:0][`DBG_WIDTH-1:0] exp_data;
	logic [`DBG_CHANNELS-1:0]                 exp_valid;
	logic [`DBG_CHANNELS-1:0]                 exp_ovf;
	logic [`DBG_CHANNELS-1:0]                 written;  // data is X until the first word

	jtag_dbg_top DUT (
		.clk48m        (clk48m),
		.jrstn         (jrstn),
		.pins          (pins),
		.rd_ack        (rd_ack),
		.mbox_data     (mbox_data),
		.mbox_valid    (mbox_valid),
		.mbox_overflow (mbox_overflow)
	);

	bind jtag_dbg_top jtag_dbg_asserts u_asserts (
		.clk48m        (clk48m),
		.jrstn         (jrstn),
		.tck_rise      (tck_rise),
		.word_strobe   (word_strobe),
		.word          (word),
		.mbox_valid    (mbox_valid),
		.mbox_overflow (mbox_overflow)
	);

	initial begin
		clk48m = 1'b0;
		forever #50 clk48m = ~clk48m;  // 100 ns period
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk48m);
		$display("timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("Testbench failed");
		$fatal(1, "watchdog expired");
	end

	task automatic report_mismatch(input string sig, input logic [`DBG_WIDTH-1:0] expected,
		input logic [`DBG_WIDTH-1:0] actual);
		$display("ERROR time=%0t %s expected %h actual %h", $time, sig, expected, actual);
		$display("Testbench failed");
		$fatal(1, "stopped at the first mismatch");
	endtask

	task automatic check_channel(input logic ch);
		assert (mbox_valid[ch] === exp_valid[ch])
			else report_mismatch($sformatf("mbox_valid[%0d]", ch),
				`DBG_WIDTH'(exp_valid[ch]), `DBG_WIDTH'(mbox_valid[ch]));
		assert (mbox_overflow[ch] === exp_ovf[ch])
			else report_mismatch($sformatf("mbox_overflow[%0d]", ch),
				`DBG_WIDTH'(exp_ovf[ch]), `DBG_WIDTH'(mbox_overflow[ch]));
		if (written[ch]) begin
			assert (mbox_data[ch] === exp_data[ch])
				else report_mismatch($sformatf("mbox_data[%0d]", ch),
					exp_data[ch], mbox_data[ch]);
		end
	endtask

	task automatic check_outputs();
		check_channel(1'b0);
		check_channel(1'b1);
	endtask

	// one tck period, levels move together with the falling edge
	task automatic tck_period(input logic tdi, input logic shift, input logic update,
		input logic ce1, input logic ce2);
		@(posedge clk48m);
		pins <= '{tdi: tdi, tck: 1'b0, shift: shift, update: update, ce1: ce1, ce2: ce2};
		repeat (TCK_HALF) @(posedge clk48m);
		pins.tck <= 1'b1;
		repeat (TCK_HALF - 1) @(posedge clk48m);
	endtask

	// select, 32 shift edges, then update; ack_at_strobe reads in the strobe cycle
	task automatic dr_access(input logic ch, input logic [`DBG_WIDTH-1:0] data,
		input logic ack_at_strobe);
		logic [`DBG_WIDTH-1:0] bits;          // still to go out, next one in bit 0
		logic [`DBG_WIDTH-1:0] sent;          // tdi bits in wire order
		logic                  valid_before;
		bits         = data;
		sent         = '0;
		valid_before = exp_valid[ch];
		tck_period(1'b0, 1'b0, 1'b0, ~ch, ch);      // ce only here, the latch keeps it
		tck_period(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);   // entering shift-dr, no data yet
		for (int n = 0; n < `DBG_WIDTH; n++) begin
			tck_period(bits[0], n < `DBG_WIDTH - 1, 1'b0, 1'b0, 1'b0);  // last on exit edge
			sent = sent | (`DBG_WIDTH'(bits[0]) << n);  // first bit ends in bit 0
			bits = bits >> 1;
		end
		// update-dr edge
		@(posedge clk48m);
		pins <= '{tdi: 1'b0, tck: 1'b0, shift: 1'b0, update: 1'b1, ce1: 1'b0, ce2: 1'b0};
		repeat (TCK_HALF) @(posedge clk48m);
		pins.tck <= 1'b1;
		for (int k = 1; k <= TCK_PERIOD; k++) begin
			@(posedge clk48m);
			if (ack_at_strobe) begin
				rd_ack[ch] <= (k == VALID_AT - 1);  // same cycle as word_strobe
			end
			@(negedge clk48m);
			if (k == VALID_AT - 1) begin
				assert (mbox_valid[ch] === valid_before)
					else report_mismatch($sformatf("mbox_valid[%0d] early", ch),
						`DBG_WIDTH'(valid_before), `DBG_WIDTH'(mbox_valid[ch]));
			end
			if (k == VALID_AT) begin
				assert (mbox_valid[ch] === 1'b1)
					else report_mismatch($sformatf("mbox_valid[%0d] late", ch),
						`DBG_WIDTH'(1'b1), `DBG_WIDTH'(mbox_valid[ch]));
			end
		end
		@(posedge clk48m);
		pins <= '0;
		if (exp_valid[ch] && !ack_at_strobe) begin
			exp_ovf[ch] = 1'b1;  // unread word overwritten
		end
		exp_valid[ch] = 1'b1;
		exp_data[ch]  = sent;
		written[ch]   = 1'b1;
		@(negedge clk48m);
		check_outputs();
	endtask

	task automatic ack_channel(input logic ch);
		@(posedge clk48m);
		rd_ack[ch] <= 1'b1;
		@(posedge clk48m);
		rd_ack[ch] <= 1'b0;
		@(negedge clk48m);
		exp_valid[ch] = 1'b0;  // data and overflow stay
		check_outputs();
	endtask

	initial begin
		void'($urandom(32'hee66));
		pins      <= '0;
		rd_ack    <= '0;
		jrstn     <= 1'b0;
		exp_data  = '0;
		exp_valid = '0;
		exp_ovf   = '0;
		written   = '0;
		repeat (5) @(posedge clk48m);
		jrstn <= 1'b1;
		@(negedge clk48m);
		check_outputs();
		repeat (4) begin                          // tck running, tap idle
			tck_period(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
			@(negedge clk48m);
			check_outputs();
		end
		dr_access(1'b0, $urandom(), 1'b0);        // IR 0x32 word, latency checked
		dr_access(1'b1, $urandom(), 1'b0);        // IR 0x38 word, channel 0 untouched
		ack_channel(1'b0);
		ack_channel(1'b1);
		dr_access(1'b1, $urandom(), 1'b0);
		dr_access(1'b1, $urandom(), 1'b0);        // overwrite before read
		ack_channel(1'b1);                        // overflow stays set
		dr_access(1'b0, $urandom(), 1'b0);
		dr_access(1'b0, $urandom(), 1'b1);        // read in the strobe cycle, no overflow
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire
